/* build.f */
+incdir+source
source/mastermind_pkg.sv
source/button_if.sv
source/tick_gen.sv
source/debouncer.sv
source/guess_editor.sv
source/code_gen.sv
source/history.sv
source/feedback.sv
source/display_driver.sv
source/mastermind.sv
sim/tb_mastermind.sv

/* sim/tb_mastermind.sv */
`timescale 1ns/10ps
`include "mastermind_macros.svh"

module tb_mastermind;

    localparam int SEL = 0;
    localparam int RIGHT = 1;
    localparam int LEFT = 2;
    localparam int UP = 3;
    localparam int DOWN = 4;
    localparam int HOLD = 6 * `TICK_DIV;   // six debounce periods
    localparam int WAIT_LIMIT = 5000;
    localparam int LIT_SPAN = 2 * `BLINK_DIV + 2;   // one full blink period

    logic        clk = 1'b0;
    logic        rst_n;
    logic        sw;
    logic [4:0]  btn;
    logic [7:0]  seg;
    logic [3:0]  an;
    wire  [11:0] leds;                     // slot k at bits [3k+2:3k]
    logic [7:0]  sw_led;

    // game model
    logic [15:0] lfsr;
    logic [11:0] code;
    logic [11:0] cur_guess;
    int          cursor;
    int          turns;
    logic [11:0] hist_guess [`MAX_TURNS];
    logic [2:0]  hist_exact [`MAX_TURNS];
    logic [2:0]  hist_partial [`MAX_TURNS];
    logic [7:0]  digit_seg [4];
    int          errors = 0;
    int          checks = 0;
    int          e_start;

    mastermind i_mastermind (
        .clk(clk), .rst_n(rst_n), .sw(sw), .btnS(btn[SEL]), .btnR(btn[RIGHT]),
        .btnL(btn[LEFT]), .btnU(btn[UP]), .btnD(btn[DOWN]), .seg(seg), .an(an),
        .rgb0_out(leds[2:0]), .rgb1_out(leds[5:3]), .rgb2_out(leds[8:6]),
        .rgb3_out(leds[11:9]), .sw_led(sw_led)
    );

    always #5 clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // taps 16,14,13,11
    endfunction

    function automatic logic [11:0] decode_code(input logic [15:0] s);
        logic [11:0] c;
        for (int k = 0; k < 4; k++) begin
            c[3*k +: 3] = 3'(int'(s[3*k +: 3]) % `NUM_COLORS);
        end
        return c;
    endfunction

    // {exact, partial}
    function automatic logic [5:0] score_of(input logic [11:0] g, input logic [11:0] c);
        int exact;
        int common;
        int ng;
        int nc;
        exact = 0;
        common = 0;
        for (int k = 0; k < 4; k++) begin
            if (g[3*k +: 3] == c[3*k +: 3]) exact++;
        end
        for (int col = 0; col < `NUM_COLORS; col++) begin
            ng = 0;
            nc = 0;
            for (int k = 0; k < 4; k++) begin
                if (int'(g[3*k +: 3]) == col) ng++;
                if (int'(c[3*k +: 3]) == col) nc++;
            end
            common += (ng < nc) ? ng : nc;
        end
        return {3'(exact), 3'(common - exact)};
    endfunction

    // hex glyphs, dp off, gfedcba active low
    function automatic logic [7:0] glyph_of(input int v);
        case (v)
            0: return 8'hc0;
            1: return 8'hf9;
            2: return 8'ha4;
            3: return 8'hb0;
            4: return 8'h99;
            5: return 8'h92;
            6: return 8'h82;
            7: return 8'hf8;
            8: return 8'h80;
            9: return 8'h90;
            default: return 8'h00;
        endcase
    endfunction

    function automatic logic [11:0] random_guess();
        logic [11:0] g;
        for (int k = 0; k < 4; k++) begin
            g[3*k +: 3] = 3'($urandom % `NUM_COLORS);
        end
        return g;
    endfunction

    task automatic check(input logic [15:0] got, input logic [15:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string what);
        $display("run stopped: %s did not happen within %0d cycles", what, WAIT_LIMIT);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic press(input int b);
        @(posedge clk);
        btn[b] <= 1'b1;
        repeat (HOLD) @(posedge clk);
        btn[b] <= 1'b0;
        repeat (HOLD) @(posedge clk);
    endtask

    // capture each digit on a fresh an transition
    task automatic read_digits();
        logic [3:0] pat;
        int n;
        for (int d = 0; d < 4; d++) begin
            pat = ~(4'b0001 << d);
            n = 0;
            @(negedge clk);
            while (an === pat) begin
                n = n + 1;
                if (n > WAIT_LIMIT) abort_run("digit scan change");
                @(negedge clk);
            end
            while (an !== pat) begin
                n = n + 1;
                if (n > WAIT_LIMIT) abort_run($sformatf("scan of digit %0d", d));
                @(negedge clk);
            end
            digit_seg[d] = seg;
        end
    endtask

    task automatic check_digits(input int e3, input int e2, input int e1, input int e0,
                                input string label);
        int expv [4];
        expv[0] = e0;
        expv[1] = e1;
        expv[2] = e2;
        expv[3] = e3;
        read_digits();
        for (int d = 0; d < 4; d++) begin
            check(digit_seg[d], glyph_of(expv[d]), $sformatf("%s, digit %0d", label, d));
        end
    endtask

    // blink_slot is the cursor in play mode, -1 in review mode
    task automatic check_leds(input logic [11:0] exp, input int blink_slot);
        int n;
        @(negedge clk);
        for (int k = 0; k < 4; k++) begin
            if (k == blink_slot) begin
                n = 0;
                // the lit phase shows up within one blink period
                while (leds[3*k +: 3] === 3'd0 && n < LIT_SPAN) begin
                    n = n + 1;
                    @(negedge clk);
                end
            end
            check(leds[3*k +: 3], exp[3*k +: 3], $sformatf("rgb led %0d", k));
        end
    endtask

    task automatic move_cursor(input int slot);
        while (cursor != slot) begin
            if ((slot - cursor + 4) % 4 == 3) begin
                press(LEFT);
                cursor = (cursor + 3) % 4;
            end else begin
                press(RIGHT);
                cursor = (cursor + 1) % 4;
            end
        end
    endtask

    task automatic enter_guess(input logic [11:0] g);
        int diff;
        for (int k = 0; k < 4; k++) begin
            move_cursor(k);
            diff = (int'(g[3*k +: 3]) - int'(cur_guess[3*k +: 3]) + `NUM_COLORS) % `NUM_COLORS;
            if (diff <= 3) repeat (diff) press(UP);
            else repeat (`NUM_COLORS - diff) press(DOWN);   // shorter way round
            cur_guess[3*k +: 3] = g[3*k +: 3];
        end
    endtask

    task automatic commit_turn();
        logic [5:0] sc;
        int status;
        press(SEL);
        sc = score_of(cur_guess, code);
        hist_guess[turns] = cur_guess;
        hist_exact[turns] = sc[5:3];
        hist_partial[turns] = sc[2:0];
        turns++;
        status = (sc[5:3] == 3'd4) ? 1 : ((turns == `MAX_TURNS) ? 2 : 0);
        check_digits(sc[5:3], sc[2:0], turns, status, $sformatf("turn %0d", turns));
        check(sw_led, 8'd1 << (turns - 1), "sw_led after commit");
    endtask

    task automatic start_new_game();
        press(SEL);
        lfsr = lfsr_step(lfsr);
        code = decode_code(lfsr);
        turns = 0;
        cur_guess = '0;
        cursor = 0;
    endtask

    task automatic reset_state();
        @(negedge clk);
        check(an, 4'hf, "an after reset");
        check(seg, 8'hff, "seg after reset");
        check(sw_led, 8'd0, "sw_led after reset");
        check_leds(12'd0, -1);
        check_digits(0, 0, 0, 0, "first scan");
    endtask

    task automatic edit_guess_pegs();
        enter_guess({3'd3, 3'd1, 3'd5, 3'd2});
        check_leds(cur_guess, cursor);
        move_cursor(1);
        press(UP);                          // 5 wraps to 0
        cur_guess[5:3] = 3'd0;
        move_cursor(2);                     // slot 1 steady while checked
        check_leds(cur_guess, cursor);
        move_cursor(1);
        press(DOWN);                        // and back to 5
        cur_guess[5:3] = 3'd5;
        check_leds(cur_guess, cursor);
    endtask

    task automatic score_random_guesses();
        logic [11:0] g;
        repeat (3) begin
            do g = random_guess(); while (g == code);
            enter_guess(g);
            commit_turn();
        end
    endtask

    task automatic win_game();
        enter_guess(code);
        commit_turn();
        press(UP);                          // ignored once the game is over
        check_leds(cur_guess, cursor);
    endtask

    task automatic show_turn(input int idx);
        check_leds(hist_guess[idx], -1);
        check_digits(hist_exact[idx], hist_partial[idx], idx, 1,
                     $sformatf("review of turn %0d", idx));
        check(sw_led, 8'd1 << idx, "sw_led in review");
    endtask

    task automatic review_turns();
        @(posedge clk);
        sw <= 1'b1;
        show_turn(turns - 1);               // starts on the newest turn
        for (int idx = turns - 2; idx >= 0; idx--) begin
            press(DOWN);
            show_turn(idx);
        end
        press(DOWN);                        // stays on the oldest
        show_turn(0);
        press(UP);
        show_turn(1);
        @(posedge clk);
        sw <= 1'b0;
    endtask

    task automatic lose_and_restart();
        logic [11:0] g;
        start_new_game();
        check_digits(0, 0, 0, 0, "new game");
        check(sw_led, 8'd0, "sw_led in new game");
        repeat (`MAX_TURNS) begin
            do g = random_guess(); while (g == code);
            enter_guess(g);
            commit_turn();
        end
        start_new_game();
        enter_guess(code);
        commit_turn();
    endtask

    task automatic report(input int n, input string name);
        $display("test %0d, %s: %0d errors", n, name, errors - e_start);
        e_start = errors;
    endtask

    initial begin
        void'($urandom(32'h771e));
        rst_n = 1'b0;
        sw = 1'b0;
        btn = '0;
        lfsr = `LFSR_SEED;
        code = decode_code(lfsr);
        cur_guess = '0;
        cursor = 0;
        turns = 0;
        e_start = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        reset_state();
        report(1, "reset state");
        edit_guess_pegs();
        report(2, "editing");
        score_random_guesses();
        report(3, "scoring");
        win_game();
        report(4, "winning");
        review_turns();
        report(5, "review mode");
        lose_and_restart();
        report(6, "loss and new game");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* source/button_if.sv */
`timescale 1ns/10ps

// one-cycle press pulses from the debouncers
interface button_if;

    logic select;
    logic left;
    logic right;
    logic up;
    logic down;

    // debouncer side
    modport source (output select, left, right, up, down);

    // consumers of the pulses
    modport sink (input select, left, right, up, down);

endinterface

/* source/code_gen.sv */
`timescale 1ns/10ps
`include "mastermind_macros.svh"

module code_gen (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  new_game,
    output mastermind_pkg::code_t code
);

    import mastermind_pkg::*;

    logic [15:0] lfsr;
    logic        fb;

    assign fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];   // taps 16,14,13,11

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= `LFSR_SEED;
        end else if (new_game) begin
            lfsr <= {lfsr[14:0], fb};   // one step per game
        end
    end

    // three bits per slot, folded into the valid colours
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            code[k] = color_t'(lfsr[3*k +: 3] % 3'(`NUM_COLORS));
        end
    end

endmodule

/* source/debouncer.sv */
`timescale 1ns/10ps
`include "mastermind_macros.svh"

module debouncer (
    input  logic clk,
    input  logic rst_n,
    input  logic db_tick,
    input  logic btn_in,
    output logic press
);

    localparam int CNT_W = $clog2(`DEBOUNCE_TICKS + 1);

    logic [1:0]       sync;         // two-flop synchronizer
    logic             state;        // debounced level
    logic [CNT_W-1:0] stable_cnt;   // ticks seen away from state

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync       <= '0;
            state      <= 1'b0;
            stable_cnt <= '0;
            press      <= 1'b0;
        end else begin
            sync  <= {sync[0], btn_in};
            press <= 1'b0;
            if (sync[1] == state) begin
                stable_cnt <= '0;   // bounced back, start over
            end else if (db_tick) begin
                if (stable_cnt == CNT_W'(`DEBOUNCE_TICKS - 1)) begin
                    state      <= sync[1];
                    stable_cnt <= '0;
                    press      <= sync[1];  // only on the rising change
                end else begin
                    stable_cnt <= stable_cnt + CNT_W'(1);
                end
            end
        end
    end

    // a press needs a full release before the next one
    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n) press |=> !press);

endmodule

/* source/display_driver.sv */
`timescale 1ns/10ps

module display_driver (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   scan_tick,
    input  logic                   blink,
    input  logic                   mode,
    input  logic [1:0]             cursor,
    input  mastermind_pkg::code_t  guess,
    input  mastermind_pkg::code_t  view_guess,
    input  mastermind_pkg::score_t view_score,
    input  mastermind_pkg::turn_t  view_turn,
    input  logic [3:0]             turn_count,
    input  logic                   win,
    input  logic                   game_over,
    output logic [7:0]             seg,
    output logic [3:0]             an,
    output mastermind_pkg::color_t rgb0_out,
    output mastermind_pkg::color_t rgb1_out,
    output mastermind_pkg::color_t rgb2_out,
    output mastermind_pkg::color_t rgb3_out,
    output logic [7:0]             sw_led
);

    logic [1:0] digit_idx;
    logic [3:0] digit_val;

    // active low, gfedcba
    function automatic logic [6:0] hex_glyph(input logic [3:0] v);
        case (v)
            4'h0: hex_glyph = 7'b1000000;
            4'h1: hex_glyph = 7'b1111001;
            4'h2: hex_glyph = 7'b0100100;
            4'h3: hex_glyph = 7'b0110000;
            4'h4: hex_glyph = 7'b0011001;
            4'h5: hex_glyph = 7'b0010010;
            4'h6: hex_glyph = 7'b0000010;
            4'h7: hex_glyph = 7'b1111000;
            4'h8: hex_glyph = 7'b0000000;
            4'h9: hex_glyph = 7'b0010000;
            4'ha: hex_glyph = 7'b0001000;
            4'hb: hex_glyph = 7'b0000011;
            4'hc: hex_glyph = 7'b1000110;
            4'hd: hex_glyph = 7'b0100001;
            4'he: hex_glyph = 7'b0000110;
            default: hex_glyph = 7'b0001110;
        endcase
    endfunction

    always_comb begin
        case (digit_idx)
            2'd3: digit_val = {1'b0, view_score.exact};
            2'd2: digit_val = {1'b0, view_score.partial};
            2'd1: digit_val = mode ? {1'b0, view_turn} : turn_count;
            default: digit_val = !game_over ? 4'd0 : (win ? 4'd1 : 4'd2);   // game status
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            digit_idx <= '0;
            an        <= 4'hf;  // all digits off
            seg       <= 8'hff;
        end else if (scan_tick) begin
            digit_idx <= digit_idx + 2'd1;
            an        <= ~(4'b0001 << digit_idx);
            seg       <= {1'b1, hex_glyph(digit_val)};   // dp held off
        end
    end

    // cursor slot goes dark on the low blink phase
    assign rgb0_out = mode ? view_guess[0] : ((cursor == 2'd0 && !blink) ? '0 : guess[0]);
    assign rgb1_out = mode ? view_guess[1] : ((cursor == 2'd1 && !blink) ? '0 : guess[1]);
    assign rgb2_out = mode ? view_guess[2] : ((cursor == 2'd2 && !blink) ? '0 : guess[2]);
    assign rgb3_out = mode ? view_guess[3] : ((cursor == 2'd3 && !blink) ? '0 : guess[3]);

    assign sw_led = (turn_count == 4'd0) ? 8'd0 :
                    mode                 ? (8'd1 << view_turn) :
                                           (8'd1 << (turn_count - 4'd1));

endmodule

/* source/feedback.sv */
`timescale 1ns/10ps
`include "mastermind_macros.svh"

module feedback (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mastermind_pkg::code_t  code,
    input  mastermind_pkg::code_t  guess,
    input  logic                   commit,
    output mastermind_pkg::score_t score,
    output logic                   win
);

    import mastermind_pkg::*;

    logic [2:0] exact_cnt;
    logic [2:0] match_cnt;                  // colour matches, any slot
    logic [2:0] guess_hist [`NUM_COLORS];
    logic [2:0] code_hist  [`NUM_COLORS];

    always_comb begin
        exact_cnt = '0;
        for (int k = 0; k < 4; k++) begin
            if (guess[k] == code[k]) begin
                exact_cnt = exact_cnt + 3'd1;
            end
        end
    end

    always_comb begin
        match_cnt = '0;
        for (int c = 0; c < `NUM_COLORS; c++) begin
            guess_hist[c] = '0;
            code_hist[c]  = '0;
            for (int k = 0; k < 4; k++) begin
                guess_hist[c] = guess_hist[c] + 3'(guess[k] == color_t'(c));
                code_hist[c]  = code_hist[c] + 3'(code[k] == color_t'(c));
            end
            // min of the two counts
            match_cnt = match_cnt + ((guess_hist[c] < code_hist[c]) ? guess_hist[c] : code_hist[c]);
        end
    end

    assign score.exact   = exact_cnt;
    assign score.partial = match_cnt - exact_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win <= 1'b0;
        end else if (commit) begin
            win <= (exact_cnt == 3'd4);
        end
    end

endmodule

/* source/guess_editor.sv */
`timescale 1ns/10ps
`include "mastermind_macros.svh"

module guess_editor (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mode,
    input  logic                  game_over,
    input  logic                  new_game,
    button_if.sink                btn,
    output mastermind_pkg::code_t guess,
    output logic [1:0]            cursor
);

    import mastermind_pkg::*;

    localparam color_t LAST_COLOR = color_t'(`NUM_COLORS - 1);

    logic edit_en;

    assign edit_en = !mode && !game_over;   // no edits while reviewing

    always_ff @(posedge clk) begin
        if (!rst_n || new_game) begin
            guess  <= '0;
            cursor <= '0;
        end else if (edit_en) begin
            if (btn.right) begin
                cursor <= cursor + 2'd1;    // wraps 3 -> 0
            end else if (btn.left) begin
                cursor <= cursor - 2'd1;
            end
            if (btn.up) begin
                guess[cursor] <= (guess[cursor] == LAST_COLOR) ? '0 : guess[cursor] + 3'd1;
            end else if (btn.down) begin
                guess[cursor] <= (guess[cursor] == '0) ? LAST_COLOR : guess[cursor] - 3'd1;
            end
        end
    end

    for (genvar k = 0; k < 4; k++) begin : g_slot_chk
        a_slot_range: assert property (@(posedge clk) disable iff (!rst_n)
            guess[k] < color_t'(`NUM_COLORS));
    end

endmodule

/* source/history.sv */
`timescale 1ns/10ps
`include "mastermind_macros.svh"

module history (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mode,
    button_if.sink                 btn,
    input  mastermind_pkg::code_t  guess,
    input  mastermind_pkg::score_t score,
    input  logic                   win,
    output logic                   commit,
    output logic                   new_game,
    output logic                   game_over,
    output logic [3:0]             turn_count,
    output mastermind_pkg::turn_t  view_turn,
    output mastermind_pkg::code_t  view_guess,
    output mastermind_pkg::score_t view_score
);

    import mastermind_pkg::*;

    code_t  guess_mem [`MAX_TURNS];
    score_t score_mem [`MAX_TURNS];
    turn_t  browse;         // turn picked in review mode
    turn_t  last_idx;
    logic   has_turns;

    assign has_turns = (turn_count != 4'd0);
    assign last_idx  = turn_t'(turn_count - 4'd1);

    // win is stale right after a new game, so it only counts once a turn exists
    assign game_over = (win && has_turns) || (turn_count == 4'(`MAX_TURNS));
    assign commit    = btn.select && !mode && !game_over;
    assign new_game  = btn.select && game_over;

    always_ff @(posedge clk) begin
        if (commit) begin
            guess_mem[turn_t'(turn_count)] <= guess;
            score_mem[turn_t'(turn_count)] <= score;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || new_game) begin
            turn_count <= '0;
            browse     <= '0;
        end else if (commit) begin
            turn_count <= turn_count + 4'd1;
            browse     <= turn_t'(turn_count);  // review starts at the newest turn
        end else if (mode && has_turns) begin
            if (btn.up && browse != last_idx) begin
                browse <= browse + 3'd1;
            end else if (btn.down && browse != '0) begin
                browse <= browse - 3'd1;
            end
        end
    end

    assign view_turn  = !has_turns ? '0 : (mode ? browse : last_idx);
    assign view_guess = has_turns ? guess_mem[view_turn] : '0;
    assign view_score = has_turns ? score_mem[view_turn] : '0;

    // once the game is over it stays over, with no commit, until a new game
    a_no_late_commit: assert property (@(posedge clk) disable iff (!rst_n)
        game_over && !new_game |=> !commit);

endmodule

/* source/mastermind.sv */
`timescale 1ns/10ps

module mastermind (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sw,          // low play, high review
    input  logic       btnS,        // select
    input  logic       btnR,
    input  logic       btnL,
    input  logic       btnU,
    input  logic       btnD,
    output logic [7:0] seg,
    output logic [3:0] an,
    output logic [2:0] rgb0_out,
    output logic [2:0] rgb1_out,
    output logic [2:0] rgb2_out,
    output logic [2:0] rgb3_out,
    output logic [7:0] sw_led
);

    import mastermind_pkg::*;

    logic       db_tick, scan_tick, blink;
    logic       commit, new_game, game_over, win;
    logic [1:0] cursor;
    logic [3:0] turn_count;
    code_t      guess, code, view_guess;
    score_t     score, view_score;
    turn_t      view_turn;

    button_if btn_bus ();

    tick_gen i_tick_gen (.clk(clk), .rst_n(rst_n), .db_tick(db_tick),
                         .scan_tick(scan_tick), .blink(blink));

    debouncer i_db_select (.clk(clk), .rst_n(rst_n), .db_tick(db_tick), .btn_in(btnS),
                           .press(btn_bus.select));
    debouncer i_db_right  (.clk(clk), .rst_n(rst_n), .db_tick(db_tick), .btn_in(btnR),
                           .press(btn_bus.right));
    debouncer i_db_left   (.clk(clk), .rst_n(rst_n), .db_tick(db_tick), .btn_in(btnL),
                           .press(btn_bus.left));
    debouncer i_db_up     (.clk(clk), .rst_n(rst_n), .db_tick(db_tick), .btn_in(btnU),
                           .press(btn_bus.up));
    debouncer i_db_down   (.clk(clk), .rst_n(rst_n), .db_tick(db_tick), .btn_in(btnD),
                           .press(btn_bus.down));

    guess_editor i_guess_editor (.clk(clk), .rst_n(rst_n), .mode(sw), .game_over(game_over),
                                 .new_game(new_game), .btn(btn_bus), .guess(guess),
                                 .cursor(cursor));

    code_gen i_code_gen (.clk(clk), .rst_n(rst_n), .new_game(new_game), .code(code));

    history i_history (.clk(clk), .rst_n(rst_n), .mode(sw), .btn(btn_bus), .guess(guess),
                       .score(score), .win(win), .commit(commit), .new_game(new_game),
                       .game_over(game_over), .turn_count(turn_count), .view_turn(view_turn),
                       .view_guess(view_guess), .view_score(view_score));

    feedback i_feedback (.clk(clk), .rst_n(rst_n), .code(code), .guess(guess),
                         .commit(commit), .score(score), .win(win));

    display_driver i_display_driver (
        .clk(clk), .rst_n(rst_n), .scan_tick(scan_tick), .blink(blink), .mode(sw),
        .cursor(cursor), .guess(guess), .view_guess(view_guess), .view_score(view_score),
        .view_turn(view_turn), .turn_count(turn_count), .win(win), .game_over(game_over),
        .seg(seg), .an(an), .rgb0_out(rgb0_out), .rgb1_out(rgb1_out),
        .rgb2_out(rgb2_out), .rgb3_out(rgb3_out), .sw_led(sw_led)
    );

endmodule

/* source/mastermind_macros.svh */
`ifndef MASTERMIND_MACROS_SVH
`define MASTERMIND_MACROS_SVH

// game rules
`define NUM_COLORS      6
`define MAX_TURNS       8

// button filtering, in db_tick strobes
`define DEBOUNCE_TICKS  4

// clk dividers, small enough for simulation
`define TICK_DIV        16
`define SCAN_DIV        64
`define BLINK_DIV       2048

`define LFSR_SEED       16'hace1    // lfsr state after reset

`endif

/* source/mastermind_pkg.sv */
package mastermind_pkg;

    // peg colour, the three bits go to an rgb led as r, g, b
    typedef logic [2:0] color_t;

    // four pegs, slot 0 is the leftmost
    typedef color_t [3:0] code_t;

    typedef struct packed {
        logic [2:0] exact;      // right colour, right slot
        logic [2:0] partial;    // right colour, wrong slot
    } score_t;

    typedef logic [2:0] turn_t;

endpackage

/* source/tick_gen.sv */
`timescale 1ns/10ps
`include "mastermind_macros.svh"

module tick_gen (
    input  logic clk,
    input  logic rst_n,
    output logic db_tick,
    output logic scan_tick,
    output logic blink
);

    localparam int DB_W    = $clog2(`TICK_DIV);
    localparam int SCAN_W  = $clog2(`SCAN_DIV);
    localparam int BLINK_W = $clog2(`BLINK_DIV);

    logic [DB_W-1:0]    db_cnt;
    logic [SCAN_W-1:0]  scan_cnt;
    logic [BLINK_W-1:0] blink_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            db_cnt    <= '0;
            scan_cnt  <= '0;
            blink_cnt <= '0;
            db_tick   <= 1'b0;
            scan_tick <= 1'b0;
            blink     <= 1'b0;
        end else begin
            db_tick   <= (db_cnt == DB_W'(`TICK_DIV - 1));     // one cycle wide
            scan_tick <= (scan_cnt == SCAN_W'(`SCAN_DIV - 1));
            db_cnt    <= (db_cnt == DB_W'(`TICK_DIV - 1)) ? '0 : db_cnt + DB_W'(1);
            scan_cnt  <= (scan_cnt == SCAN_W'(`SCAN_DIV - 1)) ? '0 : scan_cnt + SCAN_W'(1);
            if (blink_cnt == BLINK_W'(`BLINK_DIV - 1)) begin
                blink_cnt <= '0;
                blink     <= ~blink;    // level, half period per wrap
            end else begin
                blink_cnt <= blink_cnt + BLINK_W'(1);
            end
        end
    end

endmodule
